/* cache_geom_pkg.sv */
/*
 * Address, line and beat geometry of the data cache.
 * Field widths below the set index are derived here; set and way widths
 * come from the SETS and WAYS module parameters.
 */
package cache_geom_pkg;

  localparam int ADDR_W = 32;  // Byte address
  localparam int WORD_W = 64;  // Bus beat and load result

  localparam int LINE_BYTES = 64;
  localparam int OFFSET_W = $clog2(LINE_BYTES);  // Byte offset in a line

  // One bus beat carries one word of the line
  localparam int LINE_BEATS = LINE_BYTES / (WORD_W / 8);
  localparam int BEAT_W = $clog2(LINE_BEATS);

  // Byte offset inside a word
  localparam int WORD_OFF_W = OFFSET_W - BEAT_W;

endpackage

/* load_pkg.sv */
/*
 * Load kinds of the processor port and their access size and sign rules.
 */
package load_pkg;

  typedef enum logic [2:0] {
    LD, LW, LWU, LH, LHU, LB, LBU
  } load_kind_t;

  // Access size in bytes
  function automatic int unsigned kind_bytes(load_kind_t kind);
    case (kind)
      LD: return 8;
      LW, LWU: return 4;
      LH, LHU: return 2;
      default: return 1;
    endcase
  endfunction

  function automatic logic kind_signed(load_kind_t kind);
    return kind inside {LW, LH, LB};  // LD is full width anyway
  endfunction

endpackage

/* fill_if.sv */
/*
 * Refill path between the controller, the beat counter and the line array.
 * The top level feeds beat_valid and beat_data from the memory bus.
 */
interface fill_if #(
  parameter int WAYS = 4,
  parameter int SETS = 32
) ();

  logic                                  beat_valid;
  logic [cache_geom_pkg::BEAT_W-1:0]     beat_idx;   // Word index in the line
  logic [cache_geom_pkg::WORD_W-1:0]     beat_data;
  logic                                  last_beat;
  logic [$clog2(WAYS)-1:0]               fill_way;   // Victim being refilled
  logic [$clog2(SETS)-1:0]               fill_set;

  modport ctrl (input last_beat, output fill_way, output fill_set);
  modport counter (input beat_valid, output beat_idx, output last_beat);
  modport store (input beat_valid, input beat_idx, input beat_data, input last_beat,
                 input fill_way, input fill_set);

endinterface

/* beat_counter.sv */
/*
 * Counts refill beats of one line and flags the final beat.
 * last_beat is combinational, high in the cycle of the last beat strobe.
 */
module beat_counter (
  input  logic   clk,
  input  logic   reset,
  fill_if.counter cnt
);

  localparam int BEAT_W = cache_geom_pkg::BEAT_W;

  logic started;  // Between first and last beat of a line

  always_ff @(posedge clk) begin
    if (!reset) begin
      cnt.beat_idx <= '0;
      started <= 1'b0;
    end else if (cnt.beat_valid) begin
      cnt.beat_idx <= cnt.beat_idx + 1'b1;  // Wraps after the last beat
      started <= !cnt.last_beat;
    end
  end

  assign cnt.last_beat = cnt.beat_valid &&
                         (cnt.beat_idx == BEAT_W'(cache_geom_pkg::LINE_BEATS - 1));

  // A beat outside a line in progress has to open a new line
  a_beat_outside_refill : assert property (@(posedge clk) disable iff (!reset)
    cnt.beat_valid && !started |-> cnt.beat_idx == '0);

endmodule

/* tag_store.sv */
/*
 * Tags and valid bits per way and set, with all-way hit compare on the
 * registered lookup address. Each set keeps a round-robin victim pointer
 * that advances whenever a line is installed there.
 */
module tag_store #(
  parameter int WAYS = 4,
  parameter int SETS = 32
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [cache_geom_pkg::ADDR_W-1:0] lookup_addr,
  output logic                              hit,
  output logic [$clog2(WAYS)-1:0]           hit_way,
  output logic [$clog2(WAYS)-1:0]           victim_way,
  input  logic                              tag_write,
  input  logic [$clog2(WAYS)-1:0]           fill_way,
  input  logic [$clog2(SETS)-1:0]           fill_set
);

  localparam int WAY_W = $clog2(WAYS);
  localparam int SET_W = $clog2(SETS);
  localparam int OFFSET_W = cache_geom_pkg::OFFSET_W;
  localparam int TAG_W = cache_geom_pkg::ADDR_W - OFFSET_W - SET_W;

  logic [TAG_W-1:0] tags [WAYS][SETS];
  logic [WAYS-1:0]  valid [SETS];
  logic [WAY_W-1:0] rr_ptr [SETS];

  logic [SET_W-1:0] set;
  logic [TAG_W-1:0] tag;
  logic [WAYS-1:0]  hit_vec;

  assign set = lookup_addr[OFFSET_W +: SET_W];
  assign tag = lookup_addr[cache_geom_pkg::ADDR_W-1 -: TAG_W];

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      hit_vec[w] = valid[set][w] && (tags[w][set] == tag);
      if (hit_vec[w]) hit_way = WAY_W'(w);
    end
  end

  assign hit = |hit_vec;
  assign victim_way = rr_ptr[set];

  always_ff @(posedge clk) begin
    if (!reset) begin
      for (int s = 0; s < SETS; s++) begin
        valid[s] <= '0;
        rr_ptr[s] <= '0;
      end
    end else if (tag_write) begin
      valid[fill_set][fill_way] <= 1'b1;
      rr_ptr[fill_set] <= rr_ptr[fill_set] + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tag_write) tags[fill_way][fill_set] <= tag;  // Lookup still holds the missed address
  end

  // A line is only installed after a miss, so it never lives in two ways
  a_single_hit : assert property (@(posedge clk) disable iff (!reset) $onehot0(hit_vec));

endmodule

/* line_store.sv */
/*
 * Line data array. Refill beats write one word each into the victim way.
 * On a lookup the word of the hit way is registered, then the aligned
 * field is extended by load kind and registered as the response data.
 */
module line_store #(
  parameter int WAYS = 4,
  parameter int SETS = 32
) (
  input  logic                              clk,
  input  logic [cache_geom_pkg::ADDR_W-1:0] lookup_addr,
  input  load_pkg::load_kind_t              lookup_kind,
  input  logic [$clog2(WAYS)-1:0]           hit_way,
  output logic [cache_geom_pkg::WORD_W-1:0] resp_data,
  fill_if.store                             fill
);

  localparam int WORD_W = cache_geom_pkg::WORD_W;
  localparam int BEAT_W = cache_geom_pkg::BEAT_W;
  localparam int WORD_OFF_W = cache_geom_pkg::WORD_OFF_W;
  localparam int SET_W = $clog2(SETS);

  logic [WORD_W-1:0] data_mem [WAYS][SETS][cache_geom_pkg::LINE_BEATS];

  logic [WORD_W-1:0]     word_q;   // Word of the hit way
  logic [SET_W-1:0]      set;
  logic [BEAT_W-1:0]     beat;
  logic [WORD_OFF_W-1:0] byte_off;
  logic [WORD_OFF_W-1:0] field_off;
  logic [WORD_W-1:0]     shifted;
  logic                  sign_ext;
  logic [WORD_W-1:0]     field;

  assign set = lookup_addr[cache_geom_pkg::OFFSET_W +: SET_W];
  assign beat = lookup_addr[WORD_OFF_W +: BEAT_W];
  assign byte_off = lookup_addr[WORD_OFF_W-1:0];

  always_ff @(posedge clk) begin
    if (fill.beat_valid) data_mem[fill.fill_way][fill.fill_set][fill.beat_idx] <= fill.beat_data;
  end

  always_ff @(posedge clk) begin
    word_q <= data_mem[hit_way][set][beat];
  end

  always_comb begin
    // Low address bits below the access size are ignored
    field_off = byte_off & ~WORD_OFF_W'(load_pkg::kind_bytes(lookup_kind) - 1);
    shifted = word_q >> {field_off, 3'b000};
    sign_ext = load_pkg::kind_signed(lookup_kind);
    case (load_pkg::kind_bytes(lookup_kind))
      8: field = shifted;
      4: field = {{32{sign_ext & shifted[31]}}, shifted[31:0]};
      2: field = {{48{sign_ext & shifted[15]}}, shifted[15:0]};
      default: field = {{56{sign_ext & shifted[7]}}, shifted[7:0]};
    endcase
  end

  always_ff @(posedge clk) begin
    resp_data <= field;  // Valid with resp_valid
  end

endmodule

/* cache_ctrl.sv */
/*
 * Cache controller FSM. Registers a load, looks it up, and on a miss
 * requests the line, waits for the refill, installs the tag and looks up
 * again. A hit answers two cycles after the request.
 */
module cache_ctrl #(
  parameter int WAYS = 4,
  parameter int SETS = 32
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              req,
  input  logic [cache_geom_pkg::ADDR_W-1:0] addr,
  input  load_pkg::load_kind_t              kind,
  input  logic                              hit,
  input  logic [$clog2(WAYS)-1:0]           hit_way,
  input  logic [$clog2(WAYS)-1:0]           victim_way,
  output logic                              busy,
  output logic                              resp_valid,
  output logic [cache_geom_pkg::ADDR_W-1:0] lookup_addr,
  output load_pkg::load_kind_t              lookup_kind,
  output logic                              tag_write,
  output logic                              bus_reqcyc,
  output logic [cache_geom_pkg::ADDR_W-1:0] bus_req,
  input  logic                              bus_reqack,
  fill_if.ctrl                              fill
);

  localparam int OFFSET_W = cache_geom_pkg::OFFSET_W;
  localparam int SET_W = $clog2(SETS);

  typedef enum logic [2:0] {IDLE, LOOKUP, REQUEST, REFILL, INSTALL, RESPOND} state_t;
  state_t state;

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= IDLE;
      resp_valid <= 1'b0;
      bus_reqcyc <= 1'b0;
    end else begin
      resp_valid <= 1'b0;
      case (state)
        IDLE: if (req && !busy) state <= LOOKUP;
        LOOKUP: state <= hit ? RESPOND : REQUEST;
        REQUEST: begin
          bus_reqcyc <= 1'b1;
          state <= REFILL;
        end
        REFILL: begin
          if (bus_reqcyc && bus_reqack) bus_reqcyc <= 1'b0;
          if (fill.last_beat) state <= INSTALL;  // Final beat written this edge
        end
        INSTALL: state <= LOOKUP;  // Repeat lookup, now a hit
        RESPOND: begin
          resp_valid <= 1'b1;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Request and victim registers
  always_ff @(posedge clk) begin
    if (state == IDLE && req && !busy) begin
      lookup_addr <= addr;
      lookup_kind <= kind;
    end
    if (state == LOOKUP && !hit) begin
      fill.fill_way <= victim_way;
      fill.fill_set <= lookup_addr[OFFSET_W +: SET_W];
    end
  end

  assign busy = (state != IDLE) || resp_valid;  // Through the response cycle
  assign tag_write = (state == INSTALL);
  assign bus_req = {lookup_addr[cache_geom_pkg::ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  a_resp_not_during_bus : assert property (@(posedge clk) disable iff (!reset)
    !(resp_valid && bus_reqcyc));

  // The whole refill, from bus request to last beat, lies inside busy
  a_busy_through_refill : assert property (@(posedge clk) disable iff (!reset)
    bus_reqcyc || fill.last_beat |-> busy);

  // The lookup after an install must find the line in the refilled way
  a_hit_after_install : assert property (@(posedge clk) disable iff (!reset)
    state == LOOKUP && $past(state) == INSTALL |-> hit && hit_way == fill.fill_way);

endmodule

/* cache_top.sv */
/*
 * Read-only four-way data cache top level. Processor load port and
 * 64-bit memory bus as plain ports.
 */
module cache_top #(
  parameter int WAYS = 4,
  parameter int SETS = 32
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              req,
  input  logic [cache_geom_pkg::ADDR_W-1:0] addr,
  input  load_pkg::load_kind_t              kind,
  output logic                              busy,
  output logic                              resp_valid,
  output logic [cache_geom_pkg::WORD_W-1:0] resp_data,
  output logic                              bus_reqcyc,
  output logic [cache_geom_pkg::ADDR_W-1:0] bus_req,
  input  logic                              bus_reqack,
  input  logic                              bus_respcyc,
  input  logic [cache_geom_pkg::WORD_W-1:0] bus_resp
);

  logic [cache_geom_pkg::ADDR_W-1:0] lookup_addr;
  load_pkg::load_kind_t              lookup_kind;
  logic                              hit;
  logic [$clog2(WAYS)-1:0]           hit_way;
  logic [$clog2(WAYS)-1:0]           victim_way;
  logic                              tag_write;

  fill_if #(.WAYS(WAYS), .SETS(SETS)) u_fill ();

  assign u_fill.beat_valid = bus_respcyc;
  assign u_fill.beat_data = bus_resp;

  cache_ctrl #(.WAYS(WAYS), .SETS(SETS)) u_ctrl (
    .clk, .reset, .req, .addr, .kind, .hit, .hit_way, .victim_way, .busy, .resp_valid,
    .lookup_addr, .lookup_kind, .tag_write, .bus_reqcyc, .bus_req, .bus_reqack,
    .fill(u_fill.ctrl)
  );

  beat_counter u_beat_counter (.clk, .reset, .cnt(u_fill.counter));

  tag_store #(.WAYS(WAYS), .SETS(SETS)) u_tag_store (
    .clk, .reset, .lookup_addr, .hit, .hit_way, .victim_way, .tag_write,
    .fill_way(u_fill.fill_way), .fill_set(u_fill.fill_set)
  );

  line_store #(.WAYS(WAYS), .SETS(SETS)) u_line_store (
    .clk, .lookup_addr, .lookup_kind, .hit_way, .resp_data, .fill(u_fill.store)
  );

endmodule

/* mem_hash.svh */
/*
 * Memory content model used by the bus responder and the checker.
 * Each 64-bit word is a fixed hash of its word address.
 */
function automatic logic [63:0] mem_word(logic [31:0] byte_addr);
  logic [63:0] x;
  x = {3'b000, byte_addr[31:3], ~byte_addr[31:3], 3'b101};
  x = x * 64'h9E37_79B9_7F4A_7C15;
  return x ^ (x >> 31);
endfunction

/* tb_checker.sv */
/*
 * Watches the cache ports and checks every load against the hashed memory
 * and the load kind rules, plus handshake, hit latency and line refills.
 */
module tb_checker (
  input  logic                 clk, reset, req,
  input  logic [31:0]          addr,
  input  load_pkg::load_kind_t kind,
  input  logic                 busy, resp_valid,
  input  logic [63:0]          resp_data,
  input  logic                 bus_reqcyc, bus_respcyc,
  input  logic [31:0]          bus_req,
  output int unsigned          errors, loads, misses
);
  timeunit 1ns;
  timeprecision 1ps;

  `include "mem_hash.svh"

  localparam int HIT_LATENCY = 2;

  logic                 pending = 1'b0;
  logic [31:0]          pend_addr;
  load_pkg::load_kind_t pend_kind;
  int                   cycle = 0;
  int                   req_cycle;
  int unsigned          bus_reqs;
  int unsigned          beats;
  logic                 reqcyc_q = 1'b0;
  logic                 in_reset = 1'b0;
  logic                 prev_valid = 1'b0;
  logic [25:0]          prev_line;
  bit                   touched [logic [25:0]];  // Lines loaded at least once

  initial begin
    errors = 0;
    loads = 0;
    misses = 0;
  end

  // Naturally aligned field of the word, extended by kind
  function automatic logic [63:0] expected_load(logic [31:0] a, load_pkg::load_kind_t k);
    int          size;
    int          off;
    logic [63:0] value;
    logic [63:0] keep;
    case (k)
      load_pkg::LD: size = 8;
      load_pkg::LW, load_pkg::LWU: size = 4;
      load_pkg::LH, load_pkg::LHU: size = 2;
      default: size = 1;
    endcase
    off = (int'(a[2:0]) / size) * size;
    value = mem_word({a[31:3], 3'b000}) >> (8 * off);
    if (size == 8) return value;
    keep = (64'd1 << (8 * size)) - 64'd1;
    value = value & keep;
    if ((k == load_pkg::LW || k == load_pkg::LH || k == load_pkg::LB) && value[8 * size - 1])
      value = value | ~keep;  // Sign extension
    return value;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("error @%0t ns: %s", $time, msg);
  endtask

  task automatic check_response();
    logic [63:0] expected;
    logic [25:0] line;
    int          latency;
    expected = expected_load(pend_addr, pend_kind);
    line = pend_addr[31:6];
    latency = cycle - 1 - req_cycle;  // resp_valid rose one edge before this sample
    loads++;
    if (resp_data !== expected)
      report_error($sformatf("load 0x%08h %s returned 0x%016h, expected 0x%016h",
                             pend_addr, pend_kind.name(), resp_data, expected));
    if (bus_reqs > 1) report_error("more than one bus request for one load");
    if (beats != bus_reqs * 8) report_error($sformatf("%0d beats for %0d requests", beats, bus_reqs));
    if (bus_reqs == 1) misses++;
    if (!touched.exists(line) && bus_reqs == 0) report_error("first load of a line hit");
    if (prev_valid && prev_line == line && bus_reqs != 0)
      report_error("load to the line just loaded went to the bus");
    if (bus_reqs == 0 && latency != HIT_LATENCY)
      report_error($sformatf("hit answered after %0d cycles", latency));
    touched[line] = 1'b1;
    prev_line = line;
    prev_valid = 1'b1;
  endtask

  always @(posedge clk) begin
    cycle++;
    if (!reset) begin
      in_reset = 1'b1;
      pending = 1'b0;
      reqcyc_q = 1'b0;
    end else begin
      if (in_reset && (busy || resp_valid || bus_reqcyc))
        report_error("busy, resp_valid or bus_reqcyc high right after reset");
      in_reset = 1'b0;
      if ((pending || resp_valid) && !busy) report_error("busy low while a load is outstanding");
      if (!pending && !resp_valid && busy) report_error("busy high with no load outstanding");
      if (bus_reqcyc && !reqcyc_q) begin
        bus_reqs++;
        if (!pending || bus_req != {pend_addr[31:6], 6'b0})
          report_error($sformatf("bus request 0x%08h for load 0x%08h", bus_req, pend_addr));
      end
      reqcyc_q = bus_reqcyc;
      if (bus_respcyc) beats++;
      if (resp_valid) begin
        if (!pending) report_error("resp_valid with no request");
        else check_response();
        pending = 1'b0;
      end
      if (req) begin
        pending = 1'b1;
        pend_addr = addr;
        pend_kind = kind;
        req_cycle = cycle;
        bus_reqs = 0;
        beats = 0;
      end
    end
  end

endmodule

/* tb_cache.sv */
/*
 * Testbench top for the data cache. Issues random sized loads one at a time,
 * answers line requests from the hashed memory model and ends the run.
 */
module tb_cache;
  timeunit 1ns;
  timeprecision 1ps;

  `include "mem_hash.svh"

  localparam int WAYS = 4;
  localparam int SETS = 32;
  localparam int PERIOD = 8;
  localparam int NUM_LOADS = 400;
  localparam int WORST_LOAD_CYCLES = 60;  // Slowest ack, 8 beats with gaps, install, idle gap
  localparam int TIMEOUT_NS = (NUM_LOADS + 10) * WORST_LOAD_CYCLES * PERIOD;

  logic                 clk = 1'b0;
  logic                 reset, req, busy, resp_valid;
  logic [31:0]          addr;
  load_pkg::load_kind_t kind;
  logic [63:0]          resp_data;
  logic                 bus_reqcyc, bus_reqack, bus_respcyc;
  logic [31:0]          bus_req;
  logic [63:0]          bus_resp;
  int unsigned          errors, loads, misses;
  logic [31:0]          stim_state = 32'd35;
  logic [31:0]          bus_state = 32'd35;

  always #(PERIOD / 2) clk = ~clk;

  cache_top #(.WAYS(WAYS), .SETS(SETS)) u_cache_top (
    .clk, .reset, .req, .addr, .kind, .busy, .resp_valid, .resp_data,
    .bus_reqcyc, .bus_req, .bus_reqack, .bus_respcyc, .bus_resp
  );

  tb_checker u_checker (
    .clk, .reset, .req, .addr, .kind, .busy, .resp_valid, .resp_data,
    .bus_reqcyc, .bus_respcyc, .bus_req, .errors, .loads, .misses
  );

  function automatic logic [31:0] lcg(logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // 64-line window, 8 sets of 8 tags each, so four ways see conflict misses
  function automatic logic [31:0] window_addr(logic [5:0] line, logic [5:0] offset);
    return 32'h0004_0000 | (32'(line[5:3]) << (6 + $clog2(SETS))) | (32'(line[2:0]) << 6)
           | 32'(offset);
  endfunction

  initial begin : stimulus
    logic [5:0] line;
    reset = 1'b0;
    req = 1'b0;
    addr = '0;
    kind = load_pkg::LD;
    bus_reqack = 1'b0;
    bus_respcyc = 1'b0;
    bus_resp = '0;
    line = '0;
    repeat (5) @(negedge clk);
    reset = 1'b1;
    for (int n = 0; n < NUM_LOADS; n++) begin
      stim_state = lcg(stim_state);
      if (stim_state[31:30] != 2'b00) line = stim_state[21:16];  // Else same line again
      stim_state = lcg(stim_state);
      kind = load_pkg::load_kind_t'(3'(stim_state[31:24] % 7));
      addr = window_addr(line, stim_state[21:16]);
      stim_state = lcg(stim_state);
      repeat (stim_state[31:30]) @(negedge clk);
      req = 1'b1;
      @(negedge clk);
      req = 1'b0;
      while (!resp_valid) @(negedge clk);
      @(negedge clk);  // busy drops after the response cycle
    end
    repeat (4) @(negedge clk);
    $display("Loads %0d of %0d, misses %0d, errors %0d", loads, NUM_LOADS, misses, errors);
    if (errors == 0 && loads == NUM_LOADS) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Memory side: ack after 0 to 3 cycles, then eight beats with random gaps
  initial begin : responder
    logic [31:0] line_addr;
    forever begin
      @(negedge clk);
      if (bus_reqcyc) begin
        line_addr = bus_req;
        bus_state = lcg(bus_state);
        repeat (bus_state[31:30]) @(negedge clk);
        bus_reqack = 1'b1;
        @(negedge clk);
        bus_reqack = 1'b0;
        for (int b = 0; b < cache_geom_pkg::LINE_BEATS; b++) begin
          bus_state = lcg(bus_state);
          repeat (bus_state[31:30]) @(negedge clk);
          bus_respcyc = 1'b1;
          bus_resp = mem_word(line_addr + 32'(b * 8));
          @(negedge clk);
          bus_respcyc = 1'b0;
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, the DUT stopped answering loads", TIMEOUT_NS);
    $display("Checks failed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
cache_geom_pkg.sv
load_pkg.sv
fill_if.sv
beat_counter.sv
tag_store.sv
line_store.sv
cache_ctrl.sv
cache_top.sv
tb_checker.sv
tb_cache.sv

/* run.sh */
#!/bin/sh
# Builds the data cache testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f vlog.f --top-module tb_cache -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_cache)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
